// File: Makefile
# Verilator build and run of the sprite engine testbench, run from the project root
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, pass only if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module spriteEngineTb -f spriteEngine.f
	./obj_dir/VspriteEngineTb | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/spriteEngineTb.sv
// scene table applied in a loop, each scene checked two frames after its writes
// probes within a scene are listed in raster order, logic/tiles.hex read from the run dir
`timescale 1ns/100ps

module spriteEngineTb import spritePkg::*; ();

    localparam int NUM_SCENES  = 6;
    localparam int ACK_TIMEOUT = 16;
    // about three frames per test, plus handshake and frame-boundary tests
    localparam int WATCHDOG_CYCLES = (NUM_SCENES + 2) * 3 * H_TOTAL * V_TOTAL;

    typedef struct packed {
        logic [3:0]       scene;
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] y;
        logic             opaque;
        rgbT              color;
    } probeT;

    logic                    clk;
    logic                    rstn;
    logic                    hostReq;
    logic [SPRITE_IDX_W-1:0] hostAddr;
    logic [ATTR_W-1:0]       hostData;
    logic                    hostAck;
    rgbT                     rgbOut;
    logic [POS_W-1:0]        outX;
    logic [POS_W-1:0]        outY;
    logic                    outValid;

    string             sceneName [NUM_SCENES];
    logic [ATTR_W-1:0] sceneAttr [NUM_SCENES][SPRITE_NUM];
    probeT             probes [$];

    integer seed;
    int     errorCount;
    int     passCount;
    int     failCount;
    int     startErrors;

    spriteEngine dut (
        .clk      (clk),
        .rstn     (rstn),
        .hostReq  (hostReq),
        .hostAddr (hostAddr),
        .hostData (hostData),
        .hostAck  (hostAck),
        .rgbOut   (rgbOut),
        .outX     (outX),
        .outY     (outY),
        .outValid (outValid)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic checkRgb(input string name, input rgbT expected, input rgbT actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %03h actual %03h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0b actual %0b", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkPos(input string name, input logic [POS_W-1:0] expected,
                            input logic [POS_W-1:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    // pack fields at the offsets the attribute layout defines
    function automatic logic [ATTR_W-1:0] makeAttr(input int x, input int y, input int tile,
                                                   input int hFlip, input int vFlip,
                                                   input int pal);
        logic [ATTR_W-1:0] attr;
        attr = '0;
        attr[ATTR_POSX_LSB +: POS_W] = POS_W'(x);
        attr[ATTR_POSY_LSB +: POS_W] = POS_W'(y);
        attr[ATTR_TILE_LSB +: 8]     = 8'(tile);
        attr[FLAG_HFLIP]             = (hFlip != 0);
        attr[FLAG_VFLIP]             = (vFlip != 0);
        attr[FLAG_PAL_LSB +: 2]      = 2'(pal);
        return attr;
    endfunction

    // clear probes expect background, opaque ones PALETTE[pal][val]
    task automatic addProbe(input int scene, input int x, input int y, input int opaque,
                            input int pal, input int val);
        probeT p;
        p.scene  = 4'(scene);
        p.x      = POS_W'(x);
        p.y      = POS_W'(y);
        p.opaque = (opaque != 0);
        p.color  = PALETTE[pal][val];
        probes.push_back(p);
    endtask

    task automatic buildTable();
        foreach (sceneAttr[s, k]) begin
            sceneAttr[s][k] = '0;
        end
        // tile 1 edges, tile 0 sprite stays clear
        sceneName[0]    = "opaque colour";
        sceneAttr[0][0] = makeAttr(10, 8, 1, 0, 0, 2);
        sceneAttr[0][3] = makeAttr(30, 30, 0, 0, 0, 1);
        addProbe(0, 10, 7, 0, 0, 0);
        addProbe(0, 10, 8, 1, 2, 1);
        addProbe(0, 18, 8, 0, 0, 0);
        addProbe(0, 9, 12, 0, 0, 0);
        addProbe(0, 17, 15, 1, 2, 1);
        addProbe(0, 10, 16, 0, 0, 0);
        addProbe(0, 33, 33, 0, 0, 0);
        // tile 3 only lights its corner
        sceneName[1]    = "transparency";
        sceneAttr[1][0] = makeAttr(20, 20, 3, 0, 0, 1);
        sceneAttr[1][1] = makeAttr(40, 10, 0, 0, 0, 0);
        addProbe(1, 44, 14, 0, 0, 0);
        addProbe(1, 20, 20, 1, 1, 2);
        addProbe(1, 21, 20, 0, 0, 0);
        addProbe(1, 27, 27, 0, 0, 0);
        // corner moves with each flip combination
        sceneName[2]    = "tile 3 flips";
        sceneAttr[2][0] = makeAttr(4, 4, 3, 0, 0, 0);
        sceneAttr[2][1] = makeAttr(16, 4, 3, 1, 0, 0);
        sceneAttr[2][2] = makeAttr(28, 4, 3, 0, 1, 0);
        sceneAttr[2][3] = makeAttr(40, 20, 3, 1, 1, 0);
        addProbe(2, 4, 4, 1, 0, 2);
        addProbe(2, 11, 4, 0, 0, 0);
        addProbe(2, 16, 4, 0, 0, 0);
        addProbe(2, 23, 4, 1, 0, 2);
        addProbe(2, 28, 4, 0, 0, 0);
        addProbe(2, 28, 11, 1, 0, 2);
        addProbe(2, 40, 20, 0, 0, 0);
        addProbe(2, 47, 27, 1, 0, 2);
        // left half 01, right half 10, swapped on the flipped copy
        sceneName[3]    = "tile 4 hflip";
        sceneAttr[3][0] = makeAttr(8, 30, 4, 1, 0, 3);
        sceneAttr[3][1] = makeAttr(40, 30, 4, 0, 0, 0);
        addProbe(3, 8, 30, 1, 3, 2);
        addProbe(3, 12, 30, 1, 3, 1);
        addProbe(3, 40, 30, 1, 0, 1);
        addProbe(3, 47, 30, 1, 0, 2);
        addProbe(3, 11, 37, 1, 3, 2);
        addProbe(3, 15, 37, 1, 3, 1);
        // sprite 1 in front of sprite 2
        sceneName[4]    = "priority";
        sceneAttr[4][1] = makeAttr(20, 10, 2, 0, 0, 1);
        sceneAttr[4][2] = makeAttr(24, 14, 1, 0, 0, 0);
        addProbe(4, 20, 10, 1, 1, 3);
        addProbe(4, 24, 14, 1, 1, 3);
        addProbe(4, 27, 17, 1, 1, 3);
        addProbe(4, 30, 20, 1, 0, 1);
        addProbe(4, 31, 21, 1, 0, 1);
        // sprite 1 cleared, sprite 2 shows through
        sceneName[5]    = "priority reveal";
        sceneAttr[5][1] = makeAttr(20, 10, 0, 0, 0, 1);
        sceneAttr[5][2] = makeAttr(24, 14, 1, 0, 0, 0);
        addProbe(5, 20, 10, 0, 0, 0);
        addProbe(5, 24, 14, 1, 0, 1);
        addProbe(5, 27, 17, 1, 0, 1);
    endtask

    // four-phase write, entered and left 1 ns after a rising edge
    task automatic hostWrite(input logic [SPRITE_IDX_W-1:0] addr, input logic [ATTR_W-1:0] data);
        int waitCycles;
        int holdCycles;
        checkBit("hostAck idle before request", 1'b0, hostAck);
        hostReq    = 1'b1;
        hostAddr   = addr;
        hostData   = data;
        waitCycles = 0;
        do begin
            @(posedge clk);
            #1;
            waitCycles++;
        end while (!hostAck && waitCycles < ACK_TIMEOUT);
        if (!hostAck) begin
            $display("ERROR hostAck did not rise within %0d cycles of hostReq", ACK_TIMEOUT);
            errorCount++;
            hostReq = 1'b0;
            return;
        end
        // host stalls a little before releasing
        holdCycles = $unsigned($random(seed)) % 3;
        repeat (holdCycles + 1) begin
            @(posedge clk);
            #1;
            checkBit("hostAck held while hostReq high", 1'b1, hostAck);
        end
        hostReq    = 1'b0;
        waitCycles = 0;
        do begin
            @(posedge clk);
            #1;
            waitCycles++;
        end while (hostAck && waitCycles < ACK_TIMEOUT);
        if (hostAck) begin
            $display("ERROR hostAck did not fall within %0d cycles of hostReq dropping",
                     ACK_TIMEOUT);
            errorCount++;
        end
    endtask

    // advance at least one pixel, stop on the wanted output position
    task automatic findPixel(input logic [POS_W-1:0] x, input logic [POS_W-1:0] y);
        do begin
            @(posedge clk);
            #1;
        end while (!(outValid && outX == x && outY == y));
    endtask

    // last visible pixel of a row, then one pixel per cycle through blanking
    task automatic checkBlanking(input logic [POS_W-1:0] row);
        findPixel(POS_W'(GAME_W - 1), row);
        @(posedge clk);
        #1;
        checkBit("outValid in blanking", 1'b0, outValid);
        checkPos("outX in blanking", POS_W'(GAME_W), outX);
        checkPos("outY in blanking", row, outY);
        repeat (H_TOTAL - GAME_W) begin
            @(posedge clk);
            #1;
        end
        checkBit("outValid on next row", 1'b1, outValid);
        checkPos("outX on next row", '0, outX);
        checkPos("outY on next row", row + 1'b1, outY);
    endtask

    task automatic checkScene(input int s);
        foreach (probes[i]) begin
            if (int'(probes[i].scene) == s) begin
                findPixel(probes[i].x, probes[i].y);
                checkRgb($sformatf("%s (%0d,%0d)", sceneName[s], probes[i].x, probes[i].y),
                         probes[i].opaque ? probes[i].color : BG_COLOR, rgbOut);
            end
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("PASS %s", name);
            passCount++;
        end else begin
            $display("FAIL %s (%0d errors)", name, errorCount - errorsBefore);
            failCount++;
        end
    endtask

    initial begin
        seed       = 32'h1c0ead69;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        clk        = 1'b0;
        rstn       = 1'b0;
        hostReq    = 1'b0;
        hostAddr   = '0;
        hostData   = '0;
        buildTable();
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        startErrors = errorCount;
        checkBit("outValid after reset", 1'b0, outValid);
        hostWrite(2'd3, makeAttr(0, 0, 0, 0, 0, 0));
        hostWrite(2'd1, makeAttr(0, 0, 0, 0, 0, 0));
        reportTest("host handshake", startErrors);

        startErrors = errorCount;
        checkBlanking(8'd5);
        reportTest("raster blanking", startErrors);

        for (int s = 0; s < NUM_SCENES; s++) begin
            startErrors = errorCount;
            for (int k = 0; k < SPRITE_NUM; k++) begin
                hostWrite(SPRITE_IDX_W'(k), sceneAttr[s][k]);
            end
            // second frame start is surely past the swap
            findPixel(8'd0, 8'd0);
            findPixel(8'd0, 8'd0);
            checkScene(s);
            reportTest(sceneName[s], startErrors);
        end

        // palette change issued near row 10, sprite sits at row 40
        startErrors = errorCount;
        hostWrite(2'd0, makeAttr(10, 40, 1, 0, 0, 0));
        for (int k = 1; k < SPRITE_NUM; k++) begin
            hostWrite(SPRITE_IDX_W'(k), '0);
        end
        findPixel(8'd0, 8'd0);
        findPixel(8'd0, 8'd0);
        findPixel(8'd0, 8'd10);
        hostWrite(2'd0, makeAttr(10, 40, 1, 0, 0, 1));
        findPixel(8'd12, 8'd42);
        checkRgb("frame boundary same frame (12,42)", PALETTE[0][1], rgbOut);
        findPixel(8'd12, 8'd42);
        checkRgb("frame boundary next frame (12,42)", PALETTE[1][1], rgbOut);
        reportTest("frame boundary update", startErrors);

        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // bounded run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: logic/scanTimer.sv
// free-running raster over H_TOTAL x V_TOTAL, game area at the top left
// frameStart marks the last raster position, so new state applies from (0,0)
`timescale 1ns/100ps

module scanTimer import spritePkg::*; (
    input  logic             clk,
    input  logic             rstn,
    output logic [POS_W-1:0] gameX,
    output logic [POS_W-1:0] gameY,
    output logic             visible,
    output logic             frameStart
);

    logic [POS_W-1:0] xNext;
    logic [POS_W-1:0] yNext;

    // next raster position
    always_comb begin
        xNext = gameX + 1'b1;
        yNext = gameY;
        if (gameX == POS_W'(H_TOTAL - 1)) begin
            xNext = '0;
            if (gameY == POS_W'(V_TOTAL - 1)) begin
                yNext = '0;
            end else begin
                yNext = gameY + 1'b1;
            end
        end
    end

    // flags registered with the coordinates they describe
    always_ff @(posedge clk) begin
        if (!rstn) begin
            gameX      <= '0;
            gameY      <= '0;
            visible    <= 1'b0;
            frameStart <= 1'b0;
        end else begin
            gameX      <= xNext;
            gameY      <= yNext;
            visible    <= (xNext < POS_W'(GAME_W)) && (yNext < POS_W'(GAME_H));
            // high on the final blanking position, the wrap edge follows
            frameStart <= (xNext == POS_W'(H_TOTAL - 1)) && (yNext == POS_W'(V_TOTAL - 1));
        end
    end

    // one pulse per frame, and the raster sits at (0,0) right after it
    assert property (@(posedge clk) disable iff (!rstn)
        frameStart |=> (!frameStart && gameX == '0 && gameY == '0));

endmodule

// File: logic/spriteAttrTable.sv
// host writes land in a pending copy at any time
// the live copy seen by the drawers is refreshed only on frameStart
`timescale 1ns/100ps

module spriteAttrTable import spritePkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    hostReq,
    input  logic [SPRITE_IDX_W-1:0] hostAddr,
    input  logic [ATTR_W-1:0]       hostData,
    output logic                    hostAck,
    input  logic                    frameStart,
    output logic [ATTR_W-1:0]       attr0,
    output logic [ATTR_W-1:0]       attr1,
    output logic [ATTR_W-1:0]       attr2,
    output logic [ATTR_W-1:0]       attr3
);

    logic [ATTR_W-1:0] pending [SPRITE_NUM];
    logic [ATTR_W-1:0] live    [SPRITE_NUM];
    logic              writeEn;

    // a new request not yet acknowledged
    assign writeEn = hostReq && !hostAck;

    // four-phase ack, rises one cycle after req, falls one cycle after req drops
    always_ff @(posedge clk) begin
        if (!rstn) begin
            hostAck <= 1'b0;
        end else if (writeEn) begin
            hostAck <= 1'b1;
        end else if (!hostReq && hostAck) begin
            hostAck <= 1'b0;
        end
    end

    // all-zero attributes select tile 0, fully transparent
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < SPRITE_NUM; i++) begin
                pending[i] <= '0;
                live[i]    <= '0;
            end
        end else begin
            if (writeEn) begin
                pending[hostAddr] <= hostData;
            end
            // a write in the same cycle waits for the next frame
            if (frameStart) begin
                live <= pending;
            end
        end
    end

    assign attr0 = live[0];
    assign attr1 = live[1];
    assign attr2 = live[2];
    assign attr3 = live[3];

    // a new request waits until the previous ack has dropped
    assert property (@(posedge clk) disable iff (!rstn) $rose(hostReq) |-> !hostAck);
    // address held while the request is outstanding
    assert property (@(posedge clk) disable iff (!rstn)
        (hostReq && !hostAck) |=> (!hostReq || $stable(hostAddr)));

endmodule

// File: logic/spriteEngine.sv
// sprite engine top, pixel stream with no back-pressure
// rgbOut lags the raster by two cycles, outX/outY/outValid name its pixel
`timescale 1ns/100ps

module spriteEngine import spritePkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    hostReq,
    input  logic [SPRITE_IDX_W-1:0] hostAddr,
    input  logic [ATTR_W-1:0]       hostData,
    output logic                    hostAck,
    output rgbT                     rgbOut,
    output logic [POS_W-1:0]        outX,
    output logic [POS_W-1:0]        outY,
    output logic                    outValid
);

    // raster
    logic [POS_W-1:0]  gameX;
    logic [POS_W-1:0]  gameY;
    logic              visible;
    logic              frameStart;

    // live attributes, one per drawer
    logic [ATTR_W-1:0] attr [SPRITE_NUM];

    // drawer outputs
    rgbT               pixColor  [SPRITE_NUM];
    logic              pixOpaque [SPRITE_NUM];
    logic [POS_W-1:0]  tagX      [SPRITE_NUM];
    logic [POS_W-1:0]  tagY      [SPRITE_NUM];
    logic              tagValid  [SPRITE_NUM];

    scanTimer timer (
        .clk        (clk),
        .rstn       (rstn),
        .gameX      (gameX),
        .gameY      (gameY),
        .visible    (visible),
        .frameStart (frameStart)
    );

    spriteAttrTable attrTable (
        .clk        (clk),
        .rstn       (rstn),
        .hostReq    (hostReq),
        .hostAddr   (hostAddr),
        .hostData   (hostData),
        .hostAck    (hostAck),
        .frameStart (frameStart),
        .attr0      (attr[0]),
        .attr1      (attr[1]),
        .attr2      (attr[2]),
        .attr3      (attr[3])
    );

    generate
        for (genvar i = 0; i < SPRITE_NUM; i++) begin : gDraw
            tileDraw drawer (
                .clk       (clk),
                .rstn      (rstn),
                .gameX     (gameX),
                .gameY     (gameY),
                .visible   (visible),
                .attr      (attr[i]),
                .pixColor  (pixColor[i]),
                .pixOpaque (pixOpaque[i]),
                .tagX      (tagX[i]),
                .tagY      (tagY[i]),
                .tagValid  (tagValid[i])
            );
        end
    endgenerate

    // tags of drawer 0 stand for the whole stage
    spriteMixer mixer (
        .clk       (clk),
        .rstn      (rstn),
        .pixColor  (pixColor),
        .pixOpaque (pixOpaque),
        .tagX      (tagX[0]),
        .tagY      (tagY[0]),
        .tagValid  (tagValid),
        .rgbOut    (rgbOut),
        .outX      (outX),
        .outY      (outY),
        .outValid  (outValid)
    );

endmodule

// File: logic/spriteMixer.sv
// priority mix of the drawers, lowest index in front
// coordinate tags come from drawer 0, all drawers run in lockstep
`timescale 1ns/100ps

module spriteMixer import spritePkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  rgbT              pixColor  [SPRITE_NUM],
    input  logic             pixOpaque [SPRITE_NUM],
    input  logic [POS_W-1:0] tagX,
    input  logic [POS_W-1:0] tagY,
    input  logic             tagValid  [SPRITE_NUM],
    output rgbT              rgbOut,
    output logic [POS_W-1:0] outX,
    output logic [POS_W-1:0] outY,
    output logic             outValid
);

    rgbT mixColor;

    // walk from the back so the lowest opaque index overwrites last
    always_comb begin
        mixColor = BG_COLOR;
        for (int i = SPRITE_NUM - 1; i >= 0; i--) begin
            if (pixOpaque[i]) begin
                mixColor = pixColor[i];
            end
        end
    end

    // low during reset and blanking
    always_ff @(posedge clk) begin
        if (!rstn) begin
            outValid <= 1'b0;
        end else begin
            outValid <= tagValid[0];
        end
    end

    // pixel payload travels with outValid
    always_ff @(posedge clk) begin
        rgbOut <= mixColor;
        outX   <= tagX;
        outY   <= tagY;
    end

    // every drawer sees the same raster stage
    generate
        for (genvar g = 1; g < SPRITE_NUM; g++) begin : gValidCheck
            assert property (@(posedge clk) disable iff (!rstn) tagValid[g] == tagValid[0]);
        end
    endgenerate

endmodule

// File: logic/spritePkg.sv
// geometry, attribute layout and fixed palettes for the sprite engine
// entry 0 of every palette is transparent and never reaches the screen
package spritePkg;

    // sprite slots, one drawer each
    localparam int SPRITE_NUM   = 4;
    localparam int SPRITE_IDX_W = 2;

    // visible game area
    localparam int GAME_W = 64;
    localparam int GAME_H = 48;
    // raster extent including blanking
    localparam int H_TOTAL = 80;
    localparam int V_TOTAL = 56;
    localparam int POS_W   = 8;

    // tile geometry
    localparam int TILE_W     = 8;
    localparam int TILE_H     = 8;
    localparam int TILE_COUNT = 16;
    // two planes of TILE_W*TILE_H bits
    localparam int TILE_BITS  = 128;

    // attribute word {posX, posY, tileIndex, flags}
    localparam int ATTR_W        = 32;
    localparam int ATTR_POSX_LSB = 24;
    localparam int ATTR_POSY_LSB = 16;
    localparam int ATTR_TILE_LSB = 8;
    // flag bits inside the low byte
    localparam int FLAG_HFLIP    = 7;
    localparam int FLAG_VFLIP    = 6;
    localparam int FLAG_PAL_LSB  = 4;

    localparam int RGB_W = 12;
    typedef logic [RGB_W-1:0] rgbT;

    // four fixed palettes, indexed [palette][pixel value]
    localparam rgbT PALETTE [4][4] = '{
        '{12'h000, 12'hF00, 12'h0F0, 12'h00F},
        '{12'h000, 12'hFF0, 12'h0FF, 12'hF0F},
        '{12'h000, 12'h840, 12'h480, 12'h048},
        '{12'h000, 12'hFFF, 12'h888, 12'h444}
    };

    // colour of pixels no sprite covers
    localparam rgbT BG_COLOR = 12'h213;

endpackage

// File: logic/spriteTileRom.sv
// tile patterns from logic/tiles.hex, path relative to the build directory
// indices past TILE_COUNT read as an empty tile
`timescale 1ns/100ps

module spriteTileRom import spritePkg::*; (
    input  logic [7:0]           tileIndex,
    output logic [TILE_BITS-1:0] tileData
);

    logic [TILE_BITS-1:0] patterns [TILE_COUNT];

    // one 128-bit tile per line, plane 0 in the upper half
    initial begin
        $readmemh("logic/tiles.hex", patterns);
    end

    // combinational read, out-of-range gives transparent pixels
    always_comb begin
        if (tileIndex < 8'(TILE_COUNT)) begin
            tileData = patterns[tileIndex[$clog2(TILE_COUNT)-1:0]];
        end else begin
            tileData = '0;
        end
    end

endmodule

// File: logic/tileDraw.sv
// one sprite drawer, result registered one cycle after the raster position
// pixel value is {plane1 bit, plane0 bit}, value 00 is transparent
`timescale 1ns/100ps

module tileDraw import spritePkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic [POS_W-1:0]  gameX,
    input  logic [POS_W-1:0]  gameY,
    input  logic              visible,
    input  logic [ATTR_W-1:0] attr,
    output rgbT               pixColor,
    output logic              pixOpaque,
    output logic [POS_W-1:0]  tagX,
    output logic [POS_W-1:0]  tagY,
    output logic              tagValid
);

    // attribute fields
    logic [POS_W-1:0] posX;
    logic [POS_W-1:0] posY;
    logic [7:0]       tileIndex;
    logic             hFlip;
    logic             vFlip;
    logic [1:0]       palSel;

    // hit test, one bit wider so a sprite near 255 does not wrap
    logic [POS_W:0]   xEnd;
    logic [POS_W:0]   yEnd;
    logic             hitX;
    logic             hitY;
    logic             hit;

    // in-tile position and bit select
    logic [$clog2(TILE_W)-1:0]        colRaw;
    logic [$clog2(TILE_H)-1:0]        rowRaw;
    logic [$clog2(TILE_W)-1:0]        col;
    logic [$clog2(TILE_H)-1:0]        row;
    logic [$clog2(TILE_W*TILE_H)-1:0] pixIdx;
    logic [$clog2(TILE_W*TILE_H)-1:0] bitSel;

    logic [TILE_BITS-1:0]   tileData;
    logic [TILE_BITS/2-1:0] plane0;
    logic [TILE_BITS/2-1:0] plane1;
    logic [1:0]             pixVal;

    assign posX      = attr[ATTR_POSX_LSB +: POS_W];
    assign posY      = attr[ATTR_POSY_LSB +: POS_W];
    assign tileIndex = attr[ATTR_TILE_LSB +: 8];
    assign hFlip     = attr[FLAG_HFLIP];
    assign vFlip     = attr[FLAG_VFLIP];
    assign palSel    = attr[FLAG_PAL_LSB +: 2];

    assign xEnd = {1'b0, posX} + (POS_W+1)'(TILE_W);
    assign yEnd = {1'b0, posY} + (POS_W+1)'(TILE_H);
    assign hitX = ({1'b0, gameX} >= {1'b0, posX}) && ({1'b0, gameX} < xEnd);
    assign hitY = ({1'b0, gameY} >= {1'b0, posY}) && ({1'b0, gameY} < yEnd);
    assign hit  = visible && hitX && hitY;

    // offset inside the tile, only the low bits matter on a hit
    assign colRaw = $bits(colRaw)'(gameX - posX);
    assign rowRaw = $bits(rowRaw)'(gameY - posY);
    // mirror: 7 - n is the bitwise inverse for a 3-bit offset
    assign col    = hFlip ? ~colRaw : colRaw;
    assign row    = vFlip ? ~rowRaw : rowRaw;
    // row * 8 + col
    assign pixIdx = {row, col};
    // pixel 0 sits at the top bit of each plane
    assign bitSel = ~pixIdx;

    spriteTileRom tileRom (
        .tileIndex (tileIndex),
        .tileData  (tileData)
    );

    assign plane0 = tileData[TILE_BITS-1 -: TILE_BITS/2];
    assign plane1 = tileData[TILE_BITS/2-1:0];
    assign pixVal = {plane1[bitSel], plane0[bitSel]};

    // opacity and valid tag follow reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pixOpaque <= 1'b0;
            tagValid  <= 1'b0;
        end else begin
            pixOpaque <= hit && (pixVal != 2'b00);
            tagValid  <= visible;
        end
    end

    // colour and coordinate payload
    always_ff @(posedge clk) begin
        pixColor <= PALETTE[palSel][pixVal];
        tagX     <= gameX;
        tagY     <= gameY;
    end

endmodule

// File: logic/tiles.hex
// one 128-bit tile per line, plane 0 in the upper 64 bits, pixel (0,0) at the top bit of each plane
00000000000000000000000000000000
FFFFFFFFFFFFFFFF0000000000000000
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
00000000000000008000000000000000
F0F0F0F0F0F0F0F00F0F0F0F0F0F0F0F
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000

// File: spriteEngine.f
logic/spritePkg.sv
logic/scanTimer.sv
logic/spriteAttrTable.sv
logic/spriteTileRom.sv
logic/tileDraw.sv
logic/spriteMixer.sv
logic/spriteEngine.sv
dv/spriteEngineTb.sv
